/* conv_cfg_pkg.sv */
package conv_cfg_pkg;

    localparam int KW_WIDTH   = 2;
    localparam int KH_WIDTH   = 2;
    localparam int COLS_WIDTH = 10;
    localparam int CIN_WIDTH  = 10;

    // Count fields hold the value minus one.
    typedef struct packed {
        logic [KW_WIDTH-1:0]   kernel_w_1;
        logic [KH_WIDTH-1:0]   kernel_h_1;
        logic [COLS_WIDTH-1:0] cols_1;
        logic [CIN_WIDTH-1:0]  cin_1;
        logic                  is_relu;
    } conv_cfg_t;

    // IDLE waits for start, ACTIVE takes steps, DRAIN empties the pipe.
    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_DRAIN
    } run_state_t;

endpackage

/* conv_data_pkg.sv */
package conv_data_pkg;

    localparam int DATA_WIDTH   = 16;
    localparam int ACC_WIDTH    = 40;
    localparam int PROD_WIDTH   = 2 * DATA_WIDTH;
    localparam int CONV_UNITS   = 8;
    localparam int KERNEL_H_MAX = 3;
    localparam int KERNEL_W_MAX = 3;
    localparam int PIX_ROWS     = CONV_UNITS + KERNEL_H_MAX - 1;

    typedef logic signed [DATA_WIDTH-1:0] word_t;
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    localparam acc_t SAT_MAX = acc_t'((2 ** (DATA_WIDTH - 1)) - 1);
    localparam acc_t SAT_MIN = -acc_t'(2 ** (DATA_WIDTH - 1));

    // One image column, word 0 is the top row.
    typedef struct packed {
        word_t [PIX_ROWS-1:0] word;
    } pix_beat_t;

    // One kernel column, tap 0 is the top row.
    typedef struct packed {
        word_t [KERNEL_H_MAX-1:0] tap;
    } wgt_beat_t;

    typedef struct packed {
        logic                   last;
        word_t [CONV_UNITS-1:0] data;
    } out_beat_t;

endpackage

/* conv_cfg_regs.sv */
`timescale 1ns/1ps

module conv_cfg_regs (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     start,
    input  conv_cfg_pkg::conv_cfg_t  cfg,
    input  logic                     last_step,
    input  logic                     run_done,
    output conv_cfg_pkg::conv_cfg_t  cfg_q,
    output conv_cfg_pkg::run_state_t state,
    output logic                     busy,
    output logic                     cfg_error
);

    logic h_legal;
    logic w_legal;
    logic cfg_legal;

    // Heights of 1 or KERNEL_H_MAX only.
    assign h_legal   = (int'(cfg.kernel_h_1) == 0)
                    || (int'(cfg.kernel_h_1) == conv_data_pkg::KERNEL_H_MAX - 1);
    assign w_legal   = int'(cfg.kernel_w_1) < conv_data_pkg::KERNEL_W_MAX;
    assign cfg_legal = h_legal && w_legal;

    assign busy = (state != conv_cfg_pkg::RUN_IDLE);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= conv_cfg_pkg::RUN_IDLE;
            cfg_q     <= '0;
            cfg_error <= 1'b0;
        end else begin
            case (state)
                conv_cfg_pkg::RUN_IDLE: begin
                    if (start) begin
                        if (cfg_legal) begin
                            cfg_q     <= cfg;
                            cfg_error <= 1'b0;
                            state     <= conv_cfg_pkg::RUN_ACTIVE;
                        end else begin
                            cfg_error <= 1'b1; // Held until a good start.
                        end
                    end
                end
                conv_cfg_pkg::RUN_ACTIVE: begin
                    if (last_step) begin
                        state <= conv_cfg_pkg::RUN_DRAIN;
                    end
                end
                conv_cfg_pkg::RUN_DRAIN: begin
                    if (run_done) begin
                        state <= conv_cfg_pkg::RUN_IDLE;
                    end
                end
                default: begin
                    state <= conv_cfg_pkg::RUN_IDLE;
                end
            endcase
        end
    end

    // A start during a run must not disturb the latched configuration.
    a_cfg_stable: assert property (
        @(posedge aclk) disable iff (!arst_n)
        busy |=> !busy || $stable(cfg_q)
    );

endmodule

/* conv_sequencer.sv */
`timescale 1ns/1ps

module conv_sequencer (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  conv_cfg_pkg::conv_cfg_t  cfg_q,
    input  conv_cfg_pkg::run_state_t state,
    input  logic                     s_pixels_valid,
    input  logic                     s_weights_valid,
    output logic                     grant,
    output logic                     step_valid,
    output logic                     col_end,
    output logic                     col_last,
    output logic                     last_step,
    input  logic                     pop,
    output logic                     run_done
);

    logic [conv_cfg_pkg::KW_WIDTH-1:0]   kx;
    logic [conv_cfg_pkg::CIN_WIDTH-1:0]  ci;
    logic [conv_cfg_pkg::COLS_WIDTH-1:0] c;
    logic [1:0]                          pending;
    logic                                first_step;
    logic                                kx_wrap;
    logic                                ci_wrap;
    logic                                credit_ok;
    logic                                col_start;

    assign first_step = (kx == '0) && (ci == '0);
    assign kx_wrap    = (kx == cfg_q.kernel_w_1);
    assign ci_wrap    = (ci == cfg_q.cin_1);

    // A new column needs a free FIFO slot.
    assign credit_ok = !first_step || (pending < 2'd2);

    assign grant = (state == conv_cfg_pkg::RUN_ACTIVE)
                && s_pixels_valid && s_weights_valid && credit_ok;

    assign step_valid = grant;
    assign col_start  = grant && first_step;
    assign col_end    = grant && kx_wrap && ci_wrap;
    assign col_last   = (c == cfg_q.cols_1);
    assign last_step  = col_end && col_last;
    assign run_done   = (state == conv_cfg_pkg::RUN_DRAIN) && (pending == 2'd0);

    // Kx innermost, then ci, then c.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            kx <= '0;
            ci <= '0;
            c  <= '0;
        end else if (grant) begin
            if (kx_wrap) begin
                kx <= '0;
                if (ci_wrap) begin
                    ci <= '0;
                    if (col_last) begin
                        c <= '0;
                    end else begin
                        c <= c + 1'b1;
                    end
                end else begin
                    ci <= ci + 1'b1;
                end
            end else begin
                kx <= kx + 1'b1;
            end
        end
    end

    // Columns started but not yet popped.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            case ({col_start, pop})
                2'b10:   pending <= pending + 2'd1;
                2'b01:   pending <= pending - 2'd1;
                default: pending <= pending;
            endcase
        end
    end

    a_credit_limit: assert property (
        @(posedge aclk) disable iff (!arst_n)
        pending <= 2'd2
    );

    // No step may follow the last step of a run.
    a_no_step_after_last: assert property (
        @(posedge aclk) disable iff (!arst_n)
        last_step |=> !grant
    );

endmodule

/* conv_mac_array.sv */
`timescale 1ns/1ps

module conv_mac_array (
    input  logic                                          aclk,
    input  logic                                          arst_n,
    input  logic                                          step_valid,
    input  logic                                          col_end,
    input  logic                                          col_last,
    input  conv_data_pkg::pix_beat_t                      pixels,
    input  conv_data_pkg::wgt_beat_t                      weights,
    input  logic [conv_cfg_pkg::KH_WIDTH-1:0]             kernel_h_1,
    output logic                                          acc_valid,
    output conv_data_pkg::acc_t [conv_data_pkg::CONV_UNITS-1:0] acc,
    output logic                                          acc_last
);

    logic [conv_data_pkg::KERNEL_H_MAX-1:0] tap_en;

    conv_data_pkg::prod_t prod [conv_data_pkg::CONV_UNITS][conv_data_pkg::KERNEL_H_MAX];
    conv_data_pkg::acc_t  row_sum_d [conv_data_pkg::CONV_UNITS];
    conv_data_pkg::acc_t  row_sum [conv_data_pkg::CONV_UNITS];

    logic s1_valid;
    logic s1_col_end;
    logic s1_col_last;
    logic s2_valid;
    logic s2_col_end;
    logic s2_col_last;
    logic fresh;

    always_comb begin
        for (int ky = 0; ky < conv_data_pkg::KERNEL_H_MAX; ky++) begin
            tap_en[ky] = (ky <= int'(kernel_h_1));
        end
    end

    // Stage 1, products.
    always_ff @(posedge aclk) begin
        if (step_valid) begin
            for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
                for (int ky = 0; ky < conv_data_pkg::KERNEL_H_MAX; ky++) begin
                    if (tap_en[ky]) begin
                        prod[u][ky] <= pixels.word[u + ky] * weights.tap[ky];
                    end else begin
                        prod[u][ky] <= '0; // Tap beyond kernel height.
                    end
                end
            end
        end
    end

    always_comb begin
        for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
            row_sum_d[u] = '0;
            for (int ky = 0; ky < conv_data_pkg::KERNEL_H_MAX; ky++) begin
                row_sum_d[u] = row_sum_d[u] + conv_data_pkg::acc_t'(prod[u][ky]);
            end
        end
    end

    // Stage 2, row sums.
    always_ff @(posedge aclk) begin
        if (s1_valid) begin
            for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
                row_sum[u] <= row_sum_d[u];
            end
        end
    end

    // Stage 3, accumulate.
    always_ff @(posedge aclk) begin
        if (s2_valid) begin
            for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
                if (fresh) begin
                    acc[u] <= row_sum[u];
                end else begin
                    acc[u] <= acc[u] + row_sum[u];
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid    <= 1'b0;
            s1_col_end  <= 1'b0;
            s1_col_last <= 1'b0;
            s2_valid    <= 1'b0;
            s2_col_end  <= 1'b0;
            s2_col_last <= 1'b0;
            fresh       <= 1'b1;
            acc_valid   <= 1'b0;
            acc_last    <= 1'b0;
        end else begin
            s1_valid    <= step_valid;
            s1_col_end  <= step_valid && col_end;
            s1_col_last <= col_last;
            s2_valid    <= s1_valid;
            s2_col_end  <= s1_col_end;
            s2_col_last <= s1_col_last;
            acc_valid   <= s2_valid && s2_col_end;
            if (s2_valid) begin
                fresh <= s2_col_end; // Next step opens a new column.
            end
            if (s2_valid && s2_col_end) begin
                acc_last <= s2_col_last;
            end
        end
    end

endmodule

/* conv_output_stage.sv */
`timescale 1ns/1ps

module conv_output_stage (
    input  logic                                                aclk,
    input  logic                                                arst_n,
    input  logic                                                acc_valid,
    input  conv_data_pkg::acc_t [conv_data_pkg::CONV_UNITS-1:0] acc,
    input  logic                                                acc_last,
    input  logic                                                is_relu,
    output logic                                                m_valid,
    output conv_data_pkg::out_beat_t                            m_out,
    input  logic                                                m_ready,
    output logic                                                pop
);

    conv_data_pkg::out_beat_t wr_beat;
    conv_data_pkg::out_beat_t fifo_mem [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       full;

    always_comb begin : p_sat
        conv_data_pkg::word_t sat;
        wr_beat.last = acc_last;
        for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
            if (acc[u] > conv_data_pkg::SAT_MAX) begin
                sat = conv_data_pkg::word_t'(conv_data_pkg::SAT_MAX);
            end else if (acc[u] < conv_data_pkg::SAT_MIN) begin
                sat = conv_data_pkg::word_t'(conv_data_pkg::SAT_MIN);
            end else begin
                sat = acc[u][conv_data_pkg::DATA_WIDTH-1:0];
            end
            if (is_relu && sat[conv_data_pkg::DATA_WIDTH-1]) begin
                sat = '0;
            end
            wr_beat.data[u] = sat;
        end
    end

    assign push    = acc_valid;
    assign full    = (count == 2'd2);
    assign m_valid = (count != 2'd0);
    assign pop     = m_valid && m_ready;
    assign m_out   = fifo_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Credit in the sequencer keeps the FIFO from overflowing.
    a_no_overflow: assert property (
        @(posedge aclk) disable iff (!arst_n)
        push |-> !full
    );

    a_hold_stable: assert property (
        @(posedge aclk) disable iff (!arst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_out)
    );

endmodule

/* conv_engine_top.sv */
`timescale 1ns/1ps

module conv_engine_top (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     start,
    input  conv_cfg_pkg::conv_cfg_t  cfg,
    output logic                     busy,
    output logic                     cfg_error,
    input  logic                     s_pixels_valid,
    input  conv_data_pkg::pix_beat_t s_pixels,
    output logic                     s_pixels_ready,
    input  logic                     s_weights_valid,
    input  conv_data_pkg::wgt_beat_t s_weights,
    output logic                     s_weights_ready,
    output logic                     m_valid,
    output conv_data_pkg::out_beat_t m_out,
    input  logic                     m_ready
);

    conv_cfg_pkg::conv_cfg_t                             cfg_q;
    conv_cfg_pkg::run_state_t                            state;
    conv_data_pkg::acc_t [conv_data_pkg::CONV_UNITS-1:0] acc;

    logic grant;
    logic step_valid;
    logic col_end;
    logic col_last;
    logic last_step;
    logic run_done;
    logic pop;
    logic acc_valid;
    logic acc_last;

    // Joint handshake on both inputs.
    assign s_pixels_ready  = grant;
    assign s_weights_ready = grant;

    conv_cfg_regs u_cfg_regs (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .start     (start),
        .cfg       (cfg),
        .last_step (last_step),
        .run_done  (run_done),
        .cfg_q     (cfg_q),
        .state     (state),
        .busy      (busy),
        .cfg_error (cfg_error)
    );

    conv_sequencer u_sequencer (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .cfg_q           (cfg_q),
        .state           (state),
        .s_pixels_valid  (s_pixels_valid),
        .s_weights_valid (s_weights_valid),
        .grant           (grant),
        .step_valid      (step_valid),
        .col_end         (col_end),
        .col_last        (col_last),
        .last_step       (last_step),
        .pop             (pop),
        .run_done        (run_done)
    );

    conv_mac_array u_mac_array (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .step_valid (step_valid),
        .col_end    (col_end),
        .col_last   (col_last),
        .pixels     (s_pixels),
        .weights    (s_weights),
        .kernel_h_1 (cfg_q.kernel_h_1),
        .acc_valid  (acc_valid),
        .acc        (acc),
        .acc_last   (acc_last)
    );

    conv_output_stage u_output_stage (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc       (acc),
        .acc_last  (acc_last),
        .is_relu   (cfg_q.is_relu),
        .m_valid   (m_valid),
        .m_out     (m_out),
        .m_ready   (m_ready),
        .pop       (pop)
    );

endmodule

/* tb_conv_engine.sv */
`timescale 1ns/1ps

module tb_conv_engine;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 4;
    localparam int EXP_DEPTH    = 64;
    // Per test cols * steps + 40, plus reset.
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (4 * 9 + 40) + (3 * 9 + 40)
                                   + (4 * 5 + 40) + (6 * 4 + 40) + (3 * 2 + 40);

    logic                     aclk;
    logic                     arst_n;
    logic                     start;
    conv_cfg_pkg::conv_cfg_t  cfg;
    logic                     busy;
    logic                     cfg_error;
    logic                     s_pixels_valid;
    conv_data_pkg::pix_beat_t s_pixels;
    logic                     s_pixels_ready;
    logic                     s_weights_valid;
    conv_data_pkg::wgt_beat_t s_weights;
    logic                     s_weights_ready;
    logic                     m_valid;
    conv_data_pkg::out_beat_t m_out;
    logic                     m_ready;

    integer seed;
    integer ready_seed;
    logic   ready_random;
    int     errors;
    int     tests_run;
    int     tests_failed;

    conv_data_pkg::pix_beat_t pix_q [$];
    conv_data_pkg::wgt_beat_t wgt_q [$];
    conv_data_pkg::out_beat_t exp_mem [EXP_DEPTH];
    conv_data_pkg::out_beat_t exp_head;
    int                       exp_wr;
    int                       exp_rd;

    conv_engine_top u_dut (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .start           (start),
        .cfg             (cfg),
        .busy            (busy),
        .cfg_error       (cfg_error),
        .s_pixels_valid  (s_pixels_valid),
        .s_pixels        (s_pixels),
        .s_pixels_ready  (s_pixels_ready),
        .s_weights_valid (s_weights_valid),
        .s_weights       (s_weights),
        .s_weights_ready (s_weights_ready),
        .m_valid         (m_valid),
        .m_out           (m_out),
        .m_ready         (m_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    assign exp_head = exp_mem[exp_rd];

    always @(posedge aclk) begin
        if (!arst_n) begin
            exp_rd <= 0;
        end else if (m_valid && m_ready) begin
            exp_rd <= exp_rd + 1;
        end
    end

    always @(posedge aclk) begin
        if (ready_random) begin
            m_ready <= (($random(ready_seed) % 2) == 0);
        end else begin
            m_ready <= 1'b1;
        end
    end

    a_result: assert property (@(posedge aclk) disable iff (!arst_n)
        m_valid && m_ready |-> (exp_rd < exp_wr) && (m_out == exp_head)
    ) else begin
        errors++;
        $display("MISMATCH at %0t: beat %0d got %h, expected %h", $time,
                 $sampled(exp_rd), $sampled(m_out), $sampled(exp_head));
    end

    a_out_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_out)
    ) else begin
        errors++;
        $display("Error at %0t: result beat changed while held", $time);
    end

    // Both inputs share one grant, and it needs both valids and a run.
    a_joint_ready: assert property (@(posedge aclk) disable iff (!arst_n)
        (s_pixels_ready == s_weights_ready)
            && (!s_pixels_ready || (s_pixels_valid && s_weights_valid && busy))
    ) else begin
        errors++;
        $display("Error at %0t: input ready signals broke the joint handshake", $time);
    end

    // Busy is still high on the next edge, low on the one after.
    a_busy_fall: assert property (@(posedge aclk) disable iff (!arst_n)
        m_valid && m_ready && m_out.last |=> busy ##1 !busy
    ) else begin
        errors++;
        $display("Error at %0t: busy did not fall after the final beat", $time);
    end

    a_reset_values: assert property (@(posedge aclk)
        !arst_n || $rose(arst_n) |->
            !m_valid && !s_pixels_ready && !s_weights_ready && !busy && !cfg_error
    ) else begin
        errors++;
        $display("Error at %0t: outputs not idle around reset", $time);
    end

    function automatic conv_cfg_pkg::conv_cfg_t shape_cfg(input int kw, input int kh,
                                                          input int cols, input int cin,
                                                          input bit relu);
        conv_cfg_pkg::conv_cfg_t c;
        c.kernel_w_1 = conv_cfg_pkg::KW_WIDTH'(kw - 1);
        c.kernel_h_1 = conv_cfg_pkg::KH_WIDTH'(kh - 1);
        c.cols_1     = conv_cfg_pkg::COLS_WIDTH'(cols - 1);
        c.cin_1      = conv_cfg_pkg::CIN_WIDTH'(cin - 1);
        c.is_relu    = relu;
        return c;
    endfunction

    // Range 0 gives the full signed 16-bit span.
    function automatic conv_data_pkg::word_t rand_word(input int range);
        if (range == 0) begin
            return conv_data_pkg::word_t'($random(seed));
        end
        return conv_data_pkg::word_t'($random(seed) % range);
    endfunction

    function automatic conv_data_pkg::word_t clip_result(input longint s, input bit relu);
        longint lim;
        longint v;
        lim = 64'sd1 <<< (conv_data_pkg::DATA_WIDTH - 1);
        v = s;
        if (v > lim - 1) begin
            v = lim - 1;
        end else if (v < -lim) begin
            v = -lim;
        end
        if (relu && v < 0) begin
            v = 0;
        end
        return conv_data_pkg::word_t'(v);
    endfunction

    // Steps in c, ci, kx order; the expected beat closes each column.
    task automatic build_run(input conv_cfg_pkg::conv_cfg_t c_v, input int range);
        conv_data_pkg::pix_beat_t pb;
        conv_data_pkg::wgt_beat_t wb;
        conv_data_pkg::out_beat_t ob;
        longint                   sum [conv_data_pkg::CONV_UNITS];
        for (int c = 0; c <= int'(c_v.cols_1); c++) begin
            for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
                sum[u] = 0;
            end
            for (int step = 0; step < (int'(c_v.cin_1) + 1) * (int'(c_v.kernel_w_1) + 1);
                 step++) begin
                for (int r = 0; r < conv_data_pkg::PIX_ROWS; r++) begin
                    pb.word[r] = rand_word(range);
                end
                for (int t = 0; t < conv_data_pkg::KERNEL_H_MAX; t++) begin
                    wb.tap[t] = rand_word(range); // Unused taps stay random.
                end
                pix_q.push_back(pb);
                wgt_q.push_back(wb);
                for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
                    for (int ky = 0; ky <= int'(c_v.kernel_h_1); ky++) begin
                        sum[u] += longint'(pb.word[u + ky]) * longint'(wb.tap[ky]);
                    end
                end
            end
            ob.last = (c == int'(c_v.cols_1));
            for (int u = 0; u < conv_data_pkg::CONV_UNITS; u++) begin
                ob.data[u] = clip_result(sum[u], c_v.is_relu);
            end
            exp_mem[exp_wr] = ob;
            exp_wr++;
        end
    endtask

    task automatic pulse_start(input conv_cfg_pkg::conv_cfg_t c_v);
        cfg   <= c_v;
        start <= 1'b1;
        @(posedge aclk);
        start <= 1'b0;
        @(posedge aclk);
    endtask

    task automatic run_start(input conv_cfg_pkg::conv_cfg_t c_v);
        pulse_start(c_v);
        a_busy_rise: assert (busy) else begin
            errors++;
            $display("Error at %0t: busy did not rise one cycle after start", $time);
        end
    endtask

    // A held beat keeps its valid; gaps only open between transfers.
    task automatic drive_steps(input bit gaps);
        bit held;
        bit idle;
        held = 1'b0;
        while (pix_q.size() > 0) begin
            idle = gaps && !held && (($random(seed) % 4) == 0);
            s_pixels_valid  <= !idle;
            s_weights_valid <= !idle;
            s_pixels        <= pix_q[0];
            s_weights       <= wgt_q[0];
            @(posedge aclk);
            if (s_pixels_valid && s_pixels_ready) begin
                void'(pix_q.pop_front());
                void'(wgt_q.pop_front());
                held = 1'b0;
            end else begin
                held = s_pixels_valid;
            end
        end
        s_pixels_valid  <= 1'b0;
        s_weights_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        while (busy || exp_rd != exp_wr) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk); // Let the busy check finish.
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic run_conv(input string name, input conv_cfg_pkg::conv_cfg_t c_v,
                            input int range, input bit gaps);
        int errors_before;
        errors_before = errors;
        build_run(c_v, range);
        ready_random <= gaps;
        run_start(c_v);
        drive_steps(gaps);
        wait_idle();
        ready_random <= 1'b0;
        report_test(name, errors_before);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        conv_cfg_pkg::conv_cfg_t legal;
        int                      errors_before;
        seed            = 32'h9bbd;
        ready_seed      = 32'h9bbd;
        arst_n          = 1'b0;
        start           = 1'b0;
        cfg             = '0;
        s_pixels_valid  = 1'b0;
        s_pixels        = '0;
        s_weights_valid = 1'b0;
        s_weights       = '0;
        m_ready         = 1'b0;
        ready_random    = 1'b0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        exp_wr          = 0;

        repeat (RESET_CYCLES) @(posedge aclk);
        arst_n <= 1'b1;
        repeat (2) @(posedge aclk);
        report_test("reset values", 0);

        run_conv("3x3 kernel, 3 channels", shape_cfg(3, 3, 4, 3, 1'b0), 16, 1'b0);
        run_conv("ReLU and saturation", shape_cfg(3, 3, 3, 3, 1'b1), 0, 1'b0);
        run_conv("1x1 kernel, 5 channels", shape_cfg(1, 1, 4, 5, 1'b0), 100, 1'b0);
        run_conv("random gaps and stalls", shape_cfg(2, 3, 6, 2, 1'b0), 16, 1'b1);

        errors_before = errors;
        pulse_start(shape_cfg(1, 2, 2, 1, 1'b0)); // Height 2 is not a legal shape.
        a_cfg_refused: assert (cfg_error && !busy) else begin
            errors++;
            $display("Error at %0t: illegal start was not refused", $time);
        end
        legal = shape_cfg(1, 3, 3, 2, 1'b0);
        build_run(legal, 16);
        run_start(legal);
        pulse_start(shape_cfg(3, 3, 8, 1, 1'b0)); // Ignored while busy.
        drive_steps(1'b0);
        wait_idle();
        a_cfg_cleared: assert (!cfg_error) else begin
            errors++;
            $display("Error at %0t: cfg_error still set after a good start", $time);
        end
        report_test("config checks", errors_before);

        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
conv_cfg_pkg.sv
conv_data_pkg.sv
conv_cfg_regs.sv
conv_sequencer.sv
conv_mac_array.sv
conv_output_stage.sv
conv_engine_top.sv
tb_conv_engine.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_conv_engine -f filelist.f -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
